//--- dv/clock_gen.sv
// testbench clock source
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int period_ns = 20
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
            #(period_ns / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- dv/tb_mem_wb_top.sv
// memory and write-back testbench
`timescale 1ns/1ps
`default_nettype none

module tb_mem_wb_top;
    import cpu_pkg::*;

    localparam int addr_width  = 8;
    localparam int wait_cycles = 2;
    localparam int num_random  = 300;
    localparam int max_cycles  = num_random * (wait_cycles + 4) * 4;

    logic                         clk;
    logic                         reset;
    logic                         exe_valid;
    logic [exe_to_mem_bus_wd-1:0] exe_to_mem_bus;
    logic                         mem_allow_in;
    logic                         retire_ready;
    logic                         retire_valid;
    logic [31:0]                  retire_pc;
    logic                         retire_rf_we;
    logic [4:0]                   retire_rf_addr;
    logic [31:0]                  retire_rf_data;
    logic [4:0]                   dbg_raddr;
    logic [31:0]                  dbg_rdata;

    integer seed = 84;
    int     cycle_count = 0;
    int     sample_count = 0;
    int     value_errors = 0;
    int     other_errors = 0;
    int     issued = 0;
    int     retired = 0;
    int     cur_size;
    int     lat;
    int     i;
    bit     have_instr = 0;
    bit     saw_retire = 0;
    bit     stalled_prev = 0;
    logic [31:0] next_pc = 32'h0000_1000;
    logic [exe_to_mem_bus_wd-1:0] cur_bus;
    logic [31:0] held_pc;
    logic [31:0] held_data;
    logic        held_we;
    logic [4:0]  held_addr;

    // reference state, updated in issue order
    logic [31:0] model_mem [0:2**addr_width-1];
    logic [31:0] model_rf [0:31];
    logic [31:0] exp_pc_q[$];
    logic [31:0] exp_data_q[$];
    logic [31:0] exp_we_q[$];
    logic [31:0] exp_addr_q[$];

    clock_gen #(.period_ns(20)) clock_gen_inst (.clk(clk));

    mem_wb_top #(
        .ram_addr_width (addr_width),
        .ram_wait_cycles(wait_cycles)
    ) mem_wb_top_inst (
        .clk(clk), .reset(reset),
        .exe_valid(exe_valid), .exe_to_mem_bus(exe_to_mem_bus),
        .mem_allow_in(mem_allow_in), .retire_ready(retire_ready),
        .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_rf_we(retire_rf_we), .retire_rf_addr(retire_rf_addr),
        .retire_rf_data(retire_rf_data),
        .dbg_raddr(dbg_raddr), .dbg_rdata(dbg_rdata)
    );

    // watchdog
    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= max_cycles)
        begin
            $display("timeout: not all instructions retired");
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        value_errors++;
        $display("ERR t=%0t %s expected %h actual %h", $time, name, expected, actual);
    endtask

    ////////////////////////////////////////
    // stimulus generation
    // kind 0-3 store, 4-6 load, 7-9 plain alu op
    task automatic make_instr(input int kind);
        logic [31:0] r;
        r = $random(seed);
        cur_bus = '0;
        cur_bus[ebus_pc_lsb +: 32] = next_pc;
        cur_bus[ebus_store_data_lsb +: 32] = $random(seed);
        cur_bus[ebus_rf_w_addr_lsb +: 5] = r[4:0];
        cur_bus[ebus_load_type_lsb +: 3] = r[7:5];
        // 16-word window starting at byte 0x100
        cur_bus[ebus_alu_result_lsb +: 32] = {23'd0, 1'b1, 2'b00, r[11:8], r[13:12]};
        if (kind < 4)
        begin
            cur_size = r[15:14] % 3;
            cur_bus[ebus_mem_write_lsb] = 1'b1;
            case (cur_size)
                0:       cur_bus[ebus_byte_en_lsb +: 4] = 4'b0001 << r[13:12];
                1:       cur_bus[ebus_byte_en_lsb +: 4] = r[13] ? 4'b1100 : 4'b0011;
                default: cur_bus[ebus_byte_en_lsb +: 4] = 4'b1111;
            endcase
        end
        else if (kind < 7)
        begin
            cur_bus[ebus_mem_read_lsb] = 1'b1;
            cur_bus[ebus_rf_w_en_lsb] = 1'b1;
            cur_bus[ebus_byte_en_lsb +: 4] = 4'b1111;
            cur_bus[ebus_load_type_lsb +: 3] = r[20:16] % 5;
        end
        else
        begin
            cur_bus[ebus_alu_result_lsb +: 32] = $random(seed);
            cur_bus[ebus_rf_w_en_lsb] = (r[23:21] != 3'd0);
        end
        next_pc = next_pc + 32'd4;
        have_instr = 1;
    endtask

    // model update when the DUT takes the instruction
    task automatic accept_instr();
        logic [31:0] alu;
        logic [31:0] sd;
        logic [31:0] lanes;
        logic [31:0] word;
        logic [31:0] exp_data;
        logic [7:0]  ld_byte;
        logic [15:0] ld_half;
        logic [1:0]  off;
        logic [3:0]  be;
        logic [4:0]  addr;
        logic        we;
        load_type_t  lt;
        alu  = cur_bus[ebus_alu_result_lsb +: 32];
        sd   = cur_bus[ebus_store_data_lsb +: 32];
        be   = cur_bus[ebus_byte_en_lsb +: 4];
        addr = cur_bus[ebus_rf_w_addr_lsb +: 5];
        lt   = load_type_t'(cur_bus[ebus_load_type_lsb +: 3]);
        off  = alu[1:0];
        exp_data = alu;
        if (cur_bus[ebus_mem_write_lsb])
        begin
            lanes = (cur_size == 0) ? {4{sd[7:0]}} : (cur_size == 1) ? {2{sd[15:0]}} : sd;
            for (int b = 0; b < 4; b++)
                if (be[b])
                    model_mem[alu[addr_width+1:2]][8*b +: 8] = lanes[8*b +: 8];
        end
        if (cur_bus[ebus_mem_read_lsb])
        begin
            word    = model_mem[alu[addr_width+1:2]];
            ld_byte = word[8*off +: 8];
            ld_half = off[1] ? word[31:16] : word[15:0];
            case (lt)
                ld_b:    exp_data = {{24{ld_byte[7]}}, ld_byte};
                ld_bu:   exp_data = {24'd0, ld_byte};
                ld_h:    exp_data = {{16{ld_half[15]}}, ld_half};
                ld_hu:   exp_data = {16'd0, ld_half};
                default: exp_data = word;
            endcase
        end
        we = cur_bus[ebus_rf_w_en_lsb] && (addr != 5'd0);
        if (we)
            model_rf[addr] = exp_data;
        exp_pc_q.push_back(cur_bus[ebus_pc_lsb +: 32]);
        exp_data_q.push_back(exp_data);
        exp_we_q.push_back({31'd0, we});
        exp_addr_q.push_back({27'd0, addr});
        issued++;
        have_instr = 0;
    endtask

    ////////////////////////////////////////
    // sampling, always at the falling edge
    task automatic sample_outputs();
        sample_count++;
        saw_retire = (retire_valid === 1'b1);
        if (stalled_prev)
        begin
            if (retire_valid !== 1'b1)
            begin
                other_errors++;
                $display("retire_valid dropped while the retire port was stalled, t=%0t", $time);
            end
            else
            begin
                if (retire_pc !== held_pc)
                    report_mismatch("retire_pc", held_pc, retire_pc);
                if (retire_rf_we !== held_we)
                    report_mismatch("retire_rf_we", held_we, retire_rf_we);
                if (retire_rf_addr !== held_addr)
                    report_mismatch("retire_rf_addr", held_addr, retire_rf_addr);
                if (retire_rf_data !== held_data)
                    report_mismatch("retire_rf_data", held_data, retire_rf_data);
            end
        end
        if (saw_retire && retire_ready)
        begin
            retired++;
            if (exp_pc_q.size() == 0)
            begin
                other_errors++;
                $display("retire seen with no instruction outstanding, t=%0t", $time);
            end
            else
            begin
                if (retire_pc !== exp_pc_q[0])
                    report_mismatch("retire_pc", exp_pc_q[0], retire_pc);
                if (retire_rf_we !== exp_we_q[0][0])
                    report_mismatch("retire_rf_we", exp_we_q[0], retire_rf_we);
                if (retire_rf_addr !== exp_addr_q[0][4:0])
                    report_mismatch("retire_rf_addr", exp_addr_q[0], retire_rf_addr);
                if (retire_rf_data !== exp_data_q[0])
                    report_mismatch("retire_rf_data", exp_data_q[0], retire_rf_data);
                void'(exp_pc_q.pop_front());
                void'(exp_we_q.pop_front());
                void'(exp_addr_q.pop_front());
                void'(exp_data_q.pop_front());
            end
        end
        stalled_prev = saw_retire && !retire_ready;
        held_pc   = retire_pc;
        held_we   = retire_rf_we;
        held_addr = retire_rf_addr;
        held_data = retire_rf_data;
        if (exe_valid && (mem_allow_in === 1'b1))
            accept_instr();
    endtask

    task automatic run_cycle();
        @(negedge clk);
        sample_outputs();
        @(posedge clk);
        #2;
    endtask

    task automatic check_reset_outputs();
        if (retire_valid !== 1'b0)
            report_mismatch("retire_valid", 32'd0, retire_valid);
        if (mem_allow_in !== 1'b1)
            report_mismatch("mem_allow_in", 32'd1, mem_allow_in);
    endtask

    // one instruction through an empty pipeline, retire port open
    task automatic check_isolated_latency(input int kind, input int expected);
        int start_count;
        make_instr(kind);
        exe_valid = 1'b1;
        exe_to_mem_bus = cur_bus;
        retire_ready = 1'b1;
        run_cycle();
        start_count = sample_count;
        exe_valid = 1'b0;
        if (have_instr)
        begin
            other_errors++;
            $display("isolated instruction was not accepted by an empty pipeline");
        end
        do
            run_cycle();
        while (!saw_retire && (sample_count - start_count < 40));
        lat = sample_count - start_count;
        if (lat != expected)
            report_mismatch("retire latency", expected, lat);
        run_cycle();
    endtask

    ////////////////////////////////////////
    // main sequence
    initial
    begin
        reset = 1'b1;
        exe_valid = 1'b0;
        exe_to_mem_bus = '0;
        retire_ready = 1'b0;
        dbg_raddr = 5'd0;
        for (i = 0; i < 2**addr_width; i++)
            model_mem[i] = 32'd0;
        for (i = 0; i < 32; i++)
            model_rf[i] = 32'd0;

        repeat (15)
        begin
            @(negedge clk);
            check_reset_outputs();
        end
        @(posedge clk);
        #2;
        reset = 1'b0;

        // registers start cleared
        repeat (4)
        begin
            dbg_raddr = $random(seed);
            @(negedge clk);
            check_reset_outputs();
            if (dbg_rdata !== 32'd0)
                report_mismatch("dbg_rdata", 32'd0, dbg_rdata);
            @(posedge clk);
            #2;
        end

        // random traffic with stalls on both sides
        while (retired < num_random)
        begin
            if (!have_instr && issued < num_random)
                make_instr($unsigned($random(seed)) % 10);
            exe_valid = have_instr && ($unsigned($random(seed)) % 10 >= 3);
            exe_to_mem_bus = cur_bus;
            retire_ready = ($unsigned($random(seed)) % 10 >= 3);
            run_cycle();
        end

        // quiet period, any further retire is a duplicate
        exe_valid = 1'b0;
        retire_ready = 1'b1;
        repeat (wait_cycles + 4)
            run_cycle();
        if (retired != num_random || exp_pc_q.size() != 0)
        begin
            other_errors++;
            $display("retired %0d instructions of %0d issued", retired, issued);
        end

        check_isolated_latency(5, wait_cycles + 3);
        check_isolated_latency(8, 2);

        for (i = 0; i < 32; i++)
        begin
            dbg_raddr = i;
            @(negedge clk);
            if (dbg_rdata !== model_rf[i])
                report_mismatch($sformatf("dbg_rdata[%0d]", i), model_rf[i], dbg_rdata);
            @(posedge clk);
            #2;
        end

        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- mem_wb_top.f
src/cpu_pkg.sv
src/wait_counter.sv
src/mem_access_fsm.sv
src/data_ram.sv
src/mem_stage.sv
src/wb_stage.sv
src/reg_file.sv
src/mem_wb_top.sv
dv/clock_gen.sv
dv/tb_mem_wb_top.sv

//--- src/cpu_pkg.sv
// cpu back-end shared definitions
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;

    typedef enum logic [2:0] {
        ld_b,
        ld_bu,
        ld_h,
        ld_hu,
        ld_w
    } load_type_t;

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_done
    } mem_state_t;

    ////////////////////////////////////////
    // execute to memory bus, rf_w_en on top
    localparam int ebus_pc_lsb         = 0;
    localparam int ebus_alu_result_lsb = 32;
    localparam int ebus_store_data_lsb = 64;
    localparam int ebus_rf_w_addr_lsb  = 96;
    localparam int ebus_byte_en_lsb    = 101;
    localparam int ebus_mem_read_lsb   = 105;
    localparam int ebus_mem_write_lsb  = 106;
    localparam int ebus_load_type_lsb  = 107;
    localparam int ebus_rf_w_en_lsb    = 110;
    localparam int exe_to_mem_bus_wd   = 111;

    ////////////////////////////////////////
    // memory to write-back bus, two spare bits on top
    localparam int wbus_pc_lsb          = 0;
    localparam int wbus_alu_result_lsb  = 32;
    localparam int wbus_ram_r_data_lsb  = 64;
    localparam int wbus_rf_w_addr_lsb   = 96;
    localparam int wbus_byte_offset_lsb = 101;
    localparam int wbus_mem_read_lsb    = 103;
    localparam int wbus_load_type_lsb   = 104;
    localparam int wbus_rf_w_en_lsb     = 107;
    localparam int wbus_reserved_lsb    = 108;
    localparam int mem_to_wb_bus_wd     = 110;

endpackage

`default_nettype wire

//--- src/data_ram.sv
// byte-enabled data ram
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
    parameter int ram_addr_width  = 8,
    parameter int ram_wait_cycles = 2
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      req,
    input  logic                      we,
    input  logic [ram_addr_width-1:0] addr,
    input  logic [3:0]                be,
    input  cpu_pkg::word_t            wdata,
    output logic                      ack,
    output cpu_pkg::word_t            rdata
);
    import cpu_pkg::*;

    word_t mem [2**ram_addr_width];
    logic  taken_q;
    logic  start;

    // a held req counts again once its ack has passed
    assign start = req & ~taken_q;

    always_ff @(posedge clk)
    begin
        if (reset)
            taken_q <= 1'b0;
        else if (start)
            taken_q <= 1'b1;
        else if (ack | ~req)
            taken_q <= 1'b0;
    end

    wait_counter #(
        .ram_wait_cycles(ram_wait_cycles)
    ) wait_counter_inst (
        .clk    (clk),
        .reset  (reset),
        .load   (start),
        .expired(ack)
    );

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 2**ram_addr_width; i++)
                mem[i] <= '0;
        end
        else if (ack & we)
        begin
            for (int b = 0; b < 4; b++)
                if (be[b])
                    mem[addr][8*b +: 8] <= wdata[8*b +: 8];
        end
    end

    // read word held from request start through the ack
    always_ff @(posedge clk)
    begin
        if (start)
            rdata <= mem[addr];
    end

endmodule

`default_nettype wire

//--- src/mem_access_fsm.sv
// ram access sequencer
`timescale 1ns/1ps
`default_nettype none

module mem_access_fsm (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic downstream_taken,
    input  logic ram_ack,
    output logic ram_req,
    output logic access_done
);
    import cpu_pkg::*;

    mem_state_t state;
    mem_state_t state_next;

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= st_idle;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            st_idle:
                if (start)
                    state_next = st_wait;
            st_wait:
                if (ram_ack)
                begin
                    // instruction may leave in the ack cycle itself
                    if (!downstream_taken)
                        state_next = st_done;
                    else
                        state_next = start ? st_wait : st_idle;
                end
            st_done:
                if (downstream_taken)
                    state_next = start ? st_wait : st_idle;
            default:
                state_next = st_idle;
        endcase
    end

    assign ram_req     = (state == st_wait);
    assign access_done = (state == st_done) | ((state == st_wait) & ram_ack);

endmodule

`default_nettype wire

//--- src/mem_stage.sv
// memory access pipeline stage
`timescale 1ns/1ps
`default_nettype none

module mem_stage #(
    parameter int ram_addr_width = 8
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  exe_valid,
    input  logic [cpu_pkg::exe_to_mem_bus_wd-1:0] exe_to_mem_bus,
    output logic                                  mem_allow_in,
    input  logic                                  wb_allow_in,
    output logic                                  mem_to_wb_valid,
    output logic [cpu_pkg::mem_to_wb_bus_wd-1:0]  mem_to_wb_bus,
    output logic                                  ram_req,
    output logic                                  ram_we,
    output logic [ram_addr_width-1:0]             ram_addr,
    output logic [3:0]                            ram_be,
    output cpu_pkg::word_t                        ram_wdata,
    input  logic                                  ram_ack,
    input  cpu_pkg::word_t                        ram_rdata
);
    import cpu_pkg::*;

    logic                         mem_valid;
    logic                         mem_ready_go;
    logic [exe_to_mem_bus_wd-1:0] ebus_q;
    logic                         exe_fire;
    logic                         wb_fire;
    logic                         start;
    logic                         access_done;
    word_t                        rdata_q;
    word_t                        r_data;
    logic                         rf_w_en;
    logic [2:0]                   load_type;
    logic                         mem_write;
    logic                         mem_read;
    logic [3:0]                   byte_en;
    logic [4:0]                   rf_w_addr;
    word_t                        store_data;
    word_t                        alu_result;
    word_t                        pc;

    ////////////////////////////////////////
    // pipeline handshake
    assign exe_fire        = exe_valid & mem_allow_in;
    assign mem_ready_go    = (mem_read | mem_write) ? access_done : 1'b1;
    assign mem_allow_in    = ~mem_valid | (mem_ready_go & wb_allow_in);
    assign mem_to_wb_valid = mem_valid & mem_ready_go;
    assign wb_fire         = mem_to_wb_valid & wb_allow_in;

    always_ff @(posedge clk)
    begin
        if (reset)
            mem_valid <= 1'b0;
        else if (mem_allow_in)
            mem_valid <= exe_valid;
    end

    always_ff @(posedge clk)
    begin
        if (exe_fire)
            ebus_q <= exe_to_mem_bus;
    end

    assign rf_w_en    = ebus_q[ebus_rf_w_en_lsb];
    assign load_type  = ebus_q[ebus_load_type_lsb +: 3];
    assign mem_write  = ebus_q[ebus_mem_write_lsb];
    assign mem_read   = ebus_q[ebus_mem_read_lsb];
    assign byte_en    = ebus_q[ebus_byte_en_lsb +: 4];
    assign rf_w_addr  = ebus_q[ebus_rf_w_addr_lsb +: 5];
    assign store_data = ebus_q[ebus_store_data_lsb +: 32];
    assign alu_result = ebus_q[ebus_alu_result_lsb +: 32];
    assign pc         = ebus_q[ebus_pc_lsb +: 32];

    ////////////////////////////////////////
    // ram request, started as a memory op is accepted
    assign start = exe_fire & (exe_to_mem_bus[ebus_mem_read_lsb] |
                               exe_to_mem_bus[ebus_mem_write_lsb]);

    mem_access_fsm mem_access_fsm_inst (
        .clk             (clk),
        .reset           (reset),
        .start           (start),
        .downstream_taken(wb_fire),
        .ram_ack         (ram_ack),
        .ram_req         (ram_req),
        .access_done     (access_done)
    );

    assign ram_we   = ram_req & mem_write;
    assign ram_addr = alu_result[ram_addr_width+1:2];
    assign ram_be   = byte_en;

    // byte and halfword stores repeated across lanes
    always_comb
    begin
        case (byte_en)
            4'b0001, 4'b0010, 4'b0100, 4'b1000:
                ram_wdata = {4{store_data[7:0]}};
            4'b0011, 4'b1100:
                ram_wdata = {2{store_data[15:0]}};
            default:
                ram_wdata = store_data;
        endcase
    end

    // hold read data while wb stalls
    always_ff @(posedge clk)
    begin
        if (ram_ack)
            rdata_q <= ram_rdata;
    end

    assign r_data = !mem_read ? '0 : (ram_ack ? ram_rdata : rdata_q);

    assign mem_to_wb_bus = {
        2'b00,
        rf_w_en,
        load_type,
        mem_read,
        alu_result[1:0],
        rf_w_addr,
        r_data,
        alu_result,
        pc
    };

endmodule

`default_nettype wire

//--- src/mem_wb_top.sv
// memory and write-back back end
`timescale 1ns/1ps
`default_nettype none

module mem_wb_top #(
    parameter int ram_addr_width  = 8,
    parameter int ram_wait_cycles = 2
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  exe_valid,
    input  logic [cpu_pkg::exe_to_mem_bus_wd-1:0] exe_to_mem_bus,
    output logic                                  mem_allow_in,
    input  logic                                  retire_ready,
    output logic                                  retire_valid,
    output cpu_pkg::word_t                        retire_pc,
    output logic                                  retire_rf_we,
    output logic [4:0]                            retire_rf_addr,
    output cpu_pkg::word_t                        retire_rf_data,
    input  logic [4:0]                            dbg_raddr,
    output cpu_pkg::word_t                        dbg_rdata
);
    import cpu_pkg::*;

    logic                        mem_to_wb_valid;
    logic [mem_to_wb_bus_wd-1:0] mem_to_wb_bus;
    logic                        wb_allow_in;
    logic                        ram_req;
    logic                        ram_we;
    logic [ram_addr_width-1:0]   ram_addr;
    logic [3:0]                  ram_be;
    word_t                       ram_wdata;
    logic                        ram_ack;
    word_t                       ram_rdata;
    logic                        rf_we;
    logic [4:0]                  rf_waddr;
    word_t                       rf_wdata;

    mem_stage #(
        .ram_addr_width(ram_addr_width)
    ) mem_stage_inst (
        .clk(clk), .reset(reset),
        .exe_valid(exe_valid), .exe_to_mem_bus(exe_to_mem_bus),
        .mem_allow_in(mem_allow_in), .wb_allow_in(wb_allow_in),
        .mem_to_wb_valid(mem_to_wb_valid), .mem_to_wb_bus(mem_to_wb_bus),
        .ram_req(ram_req), .ram_we(ram_we), .ram_addr(ram_addr),
        .ram_be(ram_be), .ram_wdata(ram_wdata),
        .ram_ack(ram_ack), .ram_rdata(ram_rdata)
    );

    data_ram #(
        .ram_addr_width (ram_addr_width),
        .ram_wait_cycles(ram_wait_cycles)
    ) data_ram_inst (
        .clk(clk), .reset(reset),
        .req(ram_req), .we(ram_we), .addr(ram_addr), .be(ram_be),
        .wdata(ram_wdata), .ack(ram_ack), .rdata(ram_rdata)
    );

    wb_stage wb_stage_inst (
        .clk(clk), .reset(reset),
        .mem_to_wb_valid(mem_to_wb_valid), .mem_to_wb_bus(mem_to_wb_bus),
        .wb_allow_in(wb_allow_in), .retire_ready(retire_ready),
        .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_rf_we(retire_rf_we), .retire_rf_addr(retire_rf_addr),
        .retire_rf_data(retire_rf_data),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata)
    );

    reg_file reg_file_inst (
        .clk(clk), .reset(reset),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata),
        .raddr(dbg_raddr), .rdata(dbg_rdata)
    );

endmodule

`default_nettype wire

//--- src/reg_file.sv
// general purpose register file
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic           clk,
    input  logic           reset,
    input  logic           we,
    input  logic [4:0]     waddr,
    input  cpu_pkg::word_t wdata,
    input  logic [4:0]     raddr,
    output cpu_pkg::word_t rdata
);
    import cpu_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (we && (waddr != 5'd0))
            regs[waddr] <= wdata;
    end

    // r0 hardwired to zero
    assign rdata = (raddr == 5'd0) ? '0 : regs[raddr];

endmodule

`default_nettype wire

//--- src/wait_counter.sv
// ram wait-cycle counter
`timescale 1ns/1ps
`default_nettype none

module wait_counter #(
    parameter int ram_wait_cycles = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic load,
    output logic expired
);

    logic [3:0] count;
    logic       pending;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count   <= 4'd0;
            pending <= 1'b0;
        end
        else if (load)
        begin
            count   <= 4'(ram_wait_cycles);
            pending <= 1'b1;
        end
        else if (expired)
            pending <= 1'b0;
        else if (pending)
            count <= count - 4'd1;
    end

    assign expired = pending & (count == 4'd0);

endmodule

`default_nettype wire

//--- src/wb_stage.sv
// write-back pipeline stage
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 mem_to_wb_valid,
    input  logic [cpu_pkg::mem_to_wb_bus_wd-1:0] mem_to_wb_bus,
    output logic                                 wb_allow_in,
    input  logic                                 retire_ready,
    output logic                                 retire_valid,
    output cpu_pkg::word_t                       retire_pc,
    output logic                                 retire_rf_we,
    output logic [4:0]                           retire_rf_addr,
    output cpu_pkg::word_t                       retire_rf_data,
    output logic                                 rf_we,
    output logic [4:0]                           rf_waddr,
    output cpu_pkg::word_t                       rf_wdata
);
    import cpu_pkg::*;

    logic                        wb_valid;
    logic [mem_to_wb_bus_wd-1:0] wbus_q;
    logic                        rf_w_en;
    load_type_t                  load_type;
    logic                        mem_read;
    logic [1:0]                  byte_offset;
    logic [4:0]                  rf_w_addr;
    word_t                       ram_r_data;
    word_t                       alu_result;
    word_t                       pc;
    logic [7:0]                  load_byte;
    logic [15:0]                 load_half;
    word_t                       load_value;

    ////////////////////////////////////////
    // pipeline handshake
    assign wb_allow_in = ~wb_valid | retire_ready;

    always_ff @(posedge clk)
    begin
        if (reset)
            wb_valid <= 1'b0;
        else if (wb_allow_in)
            wb_valid <= mem_to_wb_valid;
    end

    always_ff @(posedge clk)
    begin
        if (mem_to_wb_valid & wb_allow_in)
            wbus_q <= mem_to_wb_bus;
    end

    assign rf_w_en     = wbus_q[wbus_rf_w_en_lsb];
    assign load_type   = load_type_t'(wbus_q[wbus_load_type_lsb +: 3]);
    assign mem_read    = wbus_q[wbus_mem_read_lsb];
    assign byte_offset = wbus_q[wbus_byte_offset_lsb +: 2];
    assign rf_w_addr   = wbus_q[wbus_rf_w_addr_lsb +: 5];
    assign ram_r_data  = wbus_q[wbus_ram_r_data_lsb +: 32];
    assign alu_result  = wbus_q[wbus_alu_result_lsb +: 32];
    assign pc          = wbus_q[wbus_pc_lsb +: 32];

    ////////////////////////////////////////
    // load extraction
    assign load_byte = ram_r_data[8*byte_offset +: 8];
    assign load_half = byte_offset[1] ? ram_r_data[31:16] : ram_r_data[15:0];

    always_comb
    begin
        case (load_type)
            ld_b:    load_value = {{24{load_byte[7]}}, load_byte};
            ld_bu:   load_value = {24'd0, load_byte};
            ld_h:    load_value = {{16{load_half[15]}}, load_half};
            ld_hu:   load_value = {16'd0, load_half};
            default: load_value = ram_r_data;
        endcase
    end

    // retire port, r0 writes dropped
    assign retire_valid   = wb_valid;
    assign retire_pc      = pc;
    assign retire_rf_we   = rf_w_en & (rf_w_addr != 5'd0);
    assign retire_rf_addr = rf_w_addr;
    assign retire_rf_data = mem_read ? load_value : alu_result;

    // register write on the retire edge
    assign rf_we    = wb_valid & retire_ready & retire_rf_we;
    assign rf_waddr = rf_w_addr;
    assign rf_wdata = retire_rf_data;

endmodule

`default_nettype wire
